// File: vlog.f
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/phase_sequencer.sv
verilog/strobe_generator.sv
verilog/control_decode.sv
tests/tb_control_decode.sv

// File: run.sh
#!/bin/sh
# Builds the control decoder testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_control_decode \
    -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation exited cleanly"
exit 0

// File: tests/control_vectors.txt
# instr flag last strobe_mask reg_file_id alu_opcode mptr_offsetin dout dout_en (all hex)
# strobe_mask runs from pc_read in bit 23 down to alu_writeu in bit 0 in strobe port order
7f50 0 1 108000 05 00 000 007f 1  # LDR r5 with a positive immediate
8030 0 1 108000 03 00 000 ff80 1  # LDR r3 with a negative immediate
c4a1 0 1 104000 0a 00 000 00c4 1  # LDRU zero-extends
1236 0 1 100002 00 00 000 0123 1  # LDA positive
f856 0 1 100002 00 00 000 ff85 1  # LDA negative
b7bc 0 1 100001 00 00 000 002d 1  # LDAU
abc7 0 1 100080 00 00 000 0abc 1  # LDMPTR zero-extends
8f18 0 1 100040 00 00 000 08f1 1  # LDMPTRU
1272 0 0 008a00 07 00 000 0000 0  # LD@MPTR r7
1272 0 0 004900 07 00 000 0000 0
1272 0 1 100020 00 00 012 0000 0
f023 0 0 020600 02 00 000 0000 0  # ST@MPTR r2
f023 0 0 010500 02 00 000 0000 0
f023 0 1 100020 00 00 0f0 0000 0
0194 0 0 008a00 09 00 000 0000 0  # LDB@MPTR r9
0194 0 1 100020 00 00 001 0000 0
7ce5 0 0 020600 0e 00 000 0000 0  # STB@MPTR r14
7ce5 0 1 100020 00 00 07c 0000 0
57dc 0 0 000004 00 00 000 0000 0  # PUSH r21
57dc 0 0 010410 15 00 000 0000 0
57dc 0 0 000004 00 00 000 0000 0
57dc 0 1 120410 15 00 000 0000 0
abcc 0 0 008810 2a 00 000 0000 0  # POP r42
abcc 0 0 000008 00 00 000 0000 0
abcc 0 0 004810 2a 00 000 0000 0
abcc 0 1 100008 00 00 000 0000 0
07ec 0 1 102000 01 00 000 0000 0  # INC r1
fffc 0 1 101000 3f 00 000 0000 0  # DEC r63
ffea 0 1 200000 00 00 000 fffe 1  # SJMP backward
040a 0 1 200000 00 00 000 0040 1  # SJMP forward
810b 1 1 200000 00 00 000 f810 1  # SJMPF taken
810b 0 1 100000 00 00 000 0000 0  # SJMPF not taken
2c5c 0 1 120000 0b 05 000 0000 0  # ALU_REG on r11
ea5c 0 1 100000 00 05 000 003a 1  # Shift with opcode2 37
1fac 0 1 100000 00 1a 000 0007 1  # Shift with opcode2 58
909d 0 1 100000 00 09 000 ff90 1  # ALU_IMM negative
253d 0 1 100000 00 03 000 0025 1  # ALU_IMM positive
123e 0 1 100000 00 00 000 0000 0  # Opcode1 1110 is a NOP
0009 0 1 100000 00 00 000 0000 0  # MOV is a NOP

// File: tests/tb_control_decode.sv
// Self-checking testbench for control_decode; run from the project root to read its vector file.
`timescale 1ns/10ps

module tb_control_decode;

    typedef struct packed {
        logic [15:0] instr;
        logic        flag;
        logic        last;
        logic [23:0] mask;
        logic [5:0]  id;
        logic [4:0]  alu;
        logic [11:0] ofs;
        logic [15:0] dout;
        logic        dout_en;
    } vector_t;

    localparam logic [23:0] FETCH_LO_MASK = 24'h880800;  // pc_read, ir_write, mem_read.
    localparam logic [23:0] FETCH_HI_MASK = 24'h440800;  // pc_readplusone, ir_writeu, mem_read.

    logic        clk, reset, flag;
    logic [15:0] instruction;
    logic        pc_read, pc_readplusone, pc_offset, pc_inc, ir_write, ir_writeu;
    logic        reg_file_read, reg_file_readu, reg_file_write, reg_file_writeu;
    logic        reg_file_inc, reg_file_dec, mem_read, mem_write;
    logic        mptr_read_abus, mptr_read_abusplus, mptr_write, mptr_writeu, mptr_offset;
    logic        sp_read_abus, sp_inc, sp_dec, alu_write, alu_writeu, dout_en;
    logic [5:0]  reg_file_id;
    logic [4:0]  alu_opcode;
    logic [11:0] mptr_offsetin;
    logic [15:0] dout;

    vector_t     vectors[$];
    logic [31:0] rng_state = 32'd89;
    string       step_label = "reset";
    // Names in mask order, from bit 23 down.
    string       strobe_names[24] = '{
        "pc_read", "pc_readplusone", "pc_offset", "pc_inc", "ir_write", "ir_writeu",
        "reg_file_read", "reg_file_readu", "reg_file_write", "reg_file_writeu",
        "reg_file_inc", "reg_file_dec", "mem_read", "mem_write", "mptr_read_abus",
        "mptr_read_abusplus", "mptr_write", "mptr_writeu", "mptr_offset", "sp_read_abus",
        "sp_inc", "sp_dec", "alu_write", "alu_writeu"};

    control_decode i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        assert (got === exp) else begin
            stop_with_error($sformatf("MISMATCH at %0d ns in %s: %s is %0h, expected %0h",
                                      $time, step_label, name, got, exp));
        end
    endtask

    task automatic check_step(input logic [23:0] mask, input logic [5:0] id,
                              input logic [4:0] alu, input logic [11:0] ofs,
                              input logic [15:0] data, input logic data_en);
        logic [23:0] got;
        got = {pc_read, pc_readplusone, pc_offset, pc_inc, ir_write, ir_writeu,
               reg_file_read, reg_file_readu, reg_file_write, reg_file_writeu,
               reg_file_inc, reg_file_dec, mem_read, mem_write, mptr_read_abus,
               mptr_read_abusplus, mptr_write, mptr_writeu, mptr_offset, sp_read_abus,
               sp_inc, sp_dec, alu_write, alu_writeu};
        for (int i = 0; i < 24; i++) begin
            check_value(strobe_names[i], 24'(got[23-i]), 24'(mask[23-i]));
        end
        check_value("reg_file_id", 24'(reg_file_id), 24'(id));
        check_value("alu_opcode", 24'(alu_opcode), 24'(alu));
        check_value("mptr_offsetin", 24'(mptr_offsetin), 24'(ofs));
        check_value("dout", 24'(dout), 24'(data));
        check_value("dout_en", 24'(dout_en), 24'(data_en));
    endtask

    // Outputs are sampled and inputs driven 5 ns after each rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_for_fetch();
        int cycles;
        cycles = 0;
        while (ir_write !== 1'b1 && cycles < 8) begin
            next_cycle();
            cycles++;
        end
        assert (ir_write === 1'b1) else
            stop_with_error("Timeout: ir_write did not rise within 8 cycles.");
    endtask

    task automatic load_vectors();
        int          fd, count, line_no;
        string       line;
        logic [31:0] f[9];
        vector_t     v;
        line_no = 0;
        fd = $fopen("tests/control_vectors.txt", "r");
        assert (fd != 0) else
            stop_with_error("The vector file tests/control_vectors.txt could not be opened.");
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() > 1 && line[0] != "#") begin
                count = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                assert (count == 9) else
                    stop_with_error($sformatf("Vector file line %0d is malformed.", line_no));
                v = {f[0][15:0], f[1][0], f[2][0], f[3][23:0], f[4][5:0], f[5][4:0],
                     f[6][11:0], f[7][15:0], f[8][0]};
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        assert (vectors.size() > 0 && vectors[$].last) else
            stop_with_error("The vector file is empty or its last instruction has no end.");
    endtask

    initial begin
        int      idx, steps;
        vector_t v;
        reset = 1'b1;
        instruction = '0;
        flag = 1'b0;
        load_vectors();
        repeat (3) begin
            next_cycle();
            check_step('0, '0, '0, '0, '0, 1'b0);
        end
        reset = 1'b0;
        step_label = "first step after reset";
        next_cycle();
        check_step(FETCH_LO_MASK, '0, '0, '0, '0, 1'b0);
        idx = 0;
        while (idx < vectors.size()) begin
            v = vectors[idx];
            wait_for_fetch();
            instruction = v.instr;
            if (v.instr[3:0] == 4'hb) begin
                flag = v.flag;  // SJMPF takes its flag from the file.
            end else begin
                rng_state = xorshift32(rng_state);
                flag = rng_state[0];
            end
            step_label = $sformatf("FETCH_HI of %h", v.instr);
            next_cycle();
            check_step(FETCH_HI_MASK, '0, '0, '0, '0, 1'b0);
            steps = 0;
            do begin
                assert (steps < 4) else
                    stop_with_error("The vector file gives one instruction more than 4 steps.");
                v = vectors[idx];
                steps++;
                idx++;
                step_label = $sformatf("execute step %0d of %h", steps, v.instr);
                next_cycle();
                check_step(v.mask, v.id, v.alu, v.ofs, v.dout, v.dout_en);
            end while (!v.last);
            step_label = $sformatf("FETCH_LO after %h", v.instr);
            next_cycle();
            check_step(FETCH_LO_MASK, '0, '0, '0, '0, 1'b0);
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: verilog/control_decode.sv
// Top level of the CPU control decoder; connects decode, phase sequencing and strobe generation.
`timescale 1ns/10ps

module control_decode (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [ctrl_pkg::WORD_W-1:0]     instruction,
    input  logic                            flag,
    output logic                            pc_read, pc_readplusone, pc_offset, pc_inc,
    output logic                            ir_write, ir_writeu,
    output logic                            reg_file_read, reg_file_readu,
    output logic                            reg_file_write, reg_file_writeu,
    output logic                            reg_file_inc, reg_file_dec,
    output logic [ctrl_pkg::REG_ID_W-1:0]   reg_file_id,
    output logic                            mem_read, mem_write,
    output logic                            mptr_read_abus, mptr_read_abusplus,
    output logic                            mptr_write, mptr_writeu, mptr_offset,
    output logic [ctrl_pkg::MPTR_OFS_W-1:0] mptr_offsetin,
    output logic                            sp_read_abus, sp_inc, sp_dec,
    output logic [ctrl_pkg::ALU_OP_W-1:0]   alu_opcode,
    output logic                            alu_write, alu_writeu,
    output logic [ctrl_pkg::WORD_W-1:0]     dout,
    output logic                            dout_en
);

    ctrl_pkg::op_t                   op;
    ctrl_pkg::phase_t                phase;
    logic                            last_step;
    logic [ctrl_pkg::REG_ID_W-1:0]   reg_id;
    logic [ctrl_pkg::WORD_W-1:0]     data_word;
    logic [ctrl_pkg::ALU_OP_W-1:0]   alu_op;    // Decoded opcode before the output register.
    logic [ctrl_pkg::MPTR_OFS_W-1:0] mptr_ofs;

    instr_decoder i_decoder (
        .instruction   (instruction),
        .op            (op),
        .reg_id        (reg_id),
        .data_word     (data_word),
        .alu_opcode    (alu_op),
        .mptr_offsetin (mptr_ofs)
    );

    phase_sequencer i_sequencer (
        .clk       (clk),
        .reset     (reset),
        .last_step (last_step),
        .phase     (phase)
    );

    // All remaining port names match the wires and outputs above.
    strobe_generator i_strobes (.*);

endmodule

// File: verilog/strobe_generator.sv
// Registered control strobes and data outputs for the current operation and phase.
`timescale 1ns/10ps

module strobe_generator (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            flag,
    input  ctrl_pkg::op_t                   op,
    input  ctrl_pkg::phase_t                phase,
    input  logic [ctrl_pkg::REG_ID_W-1:0]   reg_id,
    input  logic [ctrl_pkg::WORD_W-1:0]     data_word,
    input  logic [ctrl_pkg::ALU_OP_W-1:0]   alu_op,
    input  logic [ctrl_pkg::MPTR_OFS_W-1:0] mptr_ofs,
    output logic                            last_step,
    output logic                            pc_read, pc_readplusone, pc_offset, pc_inc,
    output logic                            ir_write, ir_writeu,
    output logic                            reg_file_read, reg_file_readu,
    output logic                            reg_file_write, reg_file_writeu,
    output logic                            reg_file_inc, reg_file_dec,
    output logic [ctrl_pkg::REG_ID_W-1:0]   reg_file_id,
    output logic                            mem_read, mem_write,
    output logic                            mptr_read_abus, mptr_read_abusplus,
    output logic                            mptr_write, mptr_writeu, mptr_offset,
    output logic [ctrl_pkg::MPTR_OFS_W-1:0] mptr_offsetin,
    output logic                            sp_read_abus, sp_inc, sp_dec,
    output logic [ctrl_pkg::ALU_OP_W-1:0]   alu_opcode,
    output logic                            alu_write, alu_writeu,
    output logic [ctrl_pkg::WORD_W-1:0]     dout,
    output logic                            dout_en
);

    logic is_load;  // Memory to register direction of the MPTR transfers.

    assign is_load = (op == ctrl_pkg::OP_LD_MPTR) || (op == ctrl_pkg::OP_LDB_MPTR);

    always_comb begin
        case (op)
            ctrl_pkg::OP_LD_MPTR, ctrl_pkg::OP_ST_MPTR: last_step = (phase == ctrl_pkg::EXEC_2);
            ctrl_pkg::OP_LDB_MPTR, ctrl_pkg::OP_STB_MPTR: last_step = (phase == ctrl_pkg::EXEC_1);
            ctrl_pkg::OP_PUSH, ctrl_pkg::OP_POP:        last_step = (phase == ctrl_pkg::EXEC_3);
            default:                                    last_step = (phase == ctrl_pkg::EXEC_0);
        endcase
    end

    always_ff @(posedge clk) begin
        {pc_read, pc_readplusone, pc_offset, pc_inc} <= 4'b0;
        {ir_write, ir_writeu} <= 2'b0;
        {reg_file_read, reg_file_readu, reg_file_write, reg_file_writeu} <= 4'b0;
        {reg_file_inc, reg_file_dec} <= 2'b0;
        {mem_read, mem_write} <= 2'b0;
        {mptr_read_abus, mptr_read_abusplus, mptr_write, mptr_writeu, mptr_offset} <= 5'b0;
        {sp_read_abus, sp_inc, sp_dec} <= 3'b0;
        {alu_write, alu_writeu} <= 2'b0;
        reg_file_id <= '0;
        mptr_offsetin <= '0;
        alu_opcode <= '0;
        dout <= '0;
        dout_en <= 1'b0;
        if (!reset) begin
            case (phase)
                ctrl_pkg::FETCH_LO: begin
                    pc_read <= 1'b1;
                    mem_read <= 1'b1;
                    ir_write <= 1'b1;
                end
                ctrl_pkg::FETCH_HI: begin
                    pc_readplusone <= 1'b1;
                    mem_read <= 1'b1;
                    ir_writeu <= 1'b1;
                end
                default: begin
                    case (op)
                        ctrl_pkg::OP_LDR, ctrl_pkg::OP_LDRU: begin
                            reg_file_write <= (op == ctrl_pkg::OP_LDR);
                            reg_file_writeu <= (op == ctrl_pkg::OP_LDRU);
                            reg_file_id <= reg_id;
                            dout <= data_word;
                            dout_en <= 1'b1;
                            pc_inc <= 1'b1;
                        end
                        ctrl_pkg::OP_LD_MPTR, ctrl_pkg::OP_ST_MPTR,
                        ctrl_pkg::OP_LDB_MPTR, ctrl_pkg::OP_STB_MPTR: begin
                            if (last_step) begin
                                mptr_offset <= 1'b1;  // Post-increment MPTR by the offset.
                                mptr_offsetin <= mptr_ofs;
                                pc_inc <= 1'b1;
                            end else begin
                                mptr_read_abus <= (phase == ctrl_pkg::EXEC_0);
                                mptr_read_abusplus <= (phase == ctrl_pkg::EXEC_1);
                                mem_read <= is_load;
                                mem_write <= !is_load;
                                reg_file_write <= is_load && (phase == ctrl_pkg::EXEC_0);
                                reg_file_writeu <= is_load && (phase == ctrl_pkg::EXEC_1);
                                reg_file_read <= !is_load && (phase == ctrl_pkg::EXEC_0);
                                reg_file_readu <= !is_load && (phase == ctrl_pkg::EXEC_1);
                                reg_file_id <= reg_id;
                            end
                        end
                        ctrl_pkg::OP_POP: begin
                            if (phase == ctrl_pkg::EXEC_0 || phase == ctrl_pkg::EXEC_2) begin
                                sp_read_abus <= 1'b1;
                                mem_read <= 1'b1;
                                reg_file_write <= (phase == ctrl_pkg::EXEC_0);
                                reg_file_writeu <= (phase == ctrl_pkg::EXEC_2);
                                reg_file_id <= reg_id;
                            end else begin
                                sp_inc <= 1'b1;
                                pc_inc <= last_step;
                            end
                        end
                        ctrl_pkg::OP_PUSH: begin
                            if (phase == ctrl_pkg::EXEC_1 || last_step) begin
                                sp_read_abus <= 1'b1;
                                mem_write <= 1'b1;
                                reg_file_readu <= (phase == ctrl_pkg::EXEC_1); // Upper byte first.
                                reg_file_read <= last_step;
                                reg_file_id <= reg_id;
                                pc_inc <= last_step;
                            end else begin
                                sp_dec <= 1'b1;
                            end
                        end
                        ctrl_pkg::OP_SJMP, ctrl_pkg::OP_SJMPF: begin
                            if (op == ctrl_pkg::OP_SJMP || flag) begin
                                pc_offset <= 1'b1;
                                dout <= data_word;
                                dout_en <= 1'b1;
                            end else begin
                                pc_inc <= 1'b1;
                            end
                        end
                        ctrl_pkg::OP_INC, ctrl_pkg::OP_DEC: begin
                            reg_file_inc <= (op == ctrl_pkg::OP_INC);
                            reg_file_dec <= (op == ctrl_pkg::OP_DEC);
                            reg_file_id <= reg_id;
                            pc_inc <= 1'b1;
                        end
                        ctrl_pkg::OP_ALU_REG: begin
                            reg_file_read <= 1'b1;
                            reg_file_id <= reg_id;
                            alu_opcode <= alu_op;
                            pc_inc <= 1'b1;
                        end
                        ctrl_pkg::OP_SHIFT_IMM, ctrl_pkg::OP_ALU_IMM: begin
                            alu_opcode <= alu_op;
                            dout <= data_word;
                            dout_en <= 1'b1;
                            pc_inc <= 1'b1;
                        end
                        ctrl_pkg::OP_LDA, ctrl_pkg::OP_LDAU: begin
                            alu_write <= (op == ctrl_pkg::OP_LDA);
                            alu_writeu <= (op == ctrl_pkg::OP_LDAU);
                            dout <= data_word;
                            dout_en <= 1'b1;
                            pc_inc <= 1'b1;
                        end
                        ctrl_pkg::OP_LDMPTR, ctrl_pkg::OP_LDMPTRU: begin
                            mptr_write <= (op == ctrl_pkg::OP_LDMPTR);
                            mptr_writeu <= (op == ctrl_pkg::OP_LDMPTRU);
                            dout <= data_word;
                            dout_en <= 1'b1;
                            pc_inc <= 1'b1;
                        end
                        default: pc_inc <= 1'b1;
                    endcase
                end
            endcase
        end
    end

    // One bus access per step, and a branch step never also steps the PC.
    a_mem_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));
    a_pc_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(pc_inc && pc_offset));

endmodule

// File: verilog/phase_sequencer.sv
// Step counter that walks each instruction through its fetch and execute phases.
`timescale 1ns/10ps

module phase_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               last_step,
    output ctrl_pkg::phase_t   phase
);

    always_ff @(posedge clk) begin
        if (reset || last_step) begin
            phase <= ctrl_pkg::FETCH_LO;
        end else begin
            phase <= ctrl_pkg::phase_t'(phase + 3'd1);
        end
    end

    // The strobe generator must end every operation by the fourth execute step.
    a_no_phase_overrun: assert property (@(posedge clk) disable iff (reset)
        phase == ctrl_pkg::EXEC_3 |-> last_step);

endmodule

// File: verilog/instr_decoder.sv
// Combinational instruction decode into an operation, register id, data word and ALU fields.
`timescale 1ns/10ps

module instr_decoder (
    input  logic [ctrl_pkg::WORD_W-1:0]     instruction,
    output ctrl_pkg::op_t                   op,
    output logic [ctrl_pkg::REG_ID_W-1:0]   reg_id,
    output logic [ctrl_pkg::WORD_W-1:0]     data_word,
    output logic [ctrl_pkg::ALU_OP_W-1:0]   alu_opcode,
    output logic [ctrl_pkg::MPTR_OFS_W-1:0] mptr_offsetin
);

    ctrl_pkg::opcode1_t              opcode1;
    logic [ctrl_pkg::R_OP2_W-1:0]    r_op2;
    logic [ctrl_pkg::E_OP2_W-1:0]    e_field;  // Opcode2 or reg1 of an E-type word.
    logic [ctrl_pkg::R_REG2_W-1:0]   r_field;  // Reg2 or immediate of an R-type word.
    logic [ctrl_pkg::E_IMM_W-1:0]    e_imm;
    logic [ctrl_pkg::T_IMM_W-1:0]    t_imm;
    logic [ctrl_pkg::WORD_W-1:0]     e_imm_sx;
    logic [ctrl_pkg::WORD_W-1:0]     e_imm_zx;
    logic [ctrl_pkg::WORD_W-1:0]     t_imm_sx;
    logic [ctrl_pkg::WORD_W-1:0]     t_imm_zx;
    logic [ctrl_pkg::WORD_W-1:0]     r_imm_zx;

    assign opcode1 = ctrl_pkg::opcode1_t'(instruction[ctrl_pkg::OPC1_LSB +: ctrl_pkg::OPC1_W]);
    assign r_op2   = instruction[ctrl_pkg::R_OP2_LSB +: ctrl_pkg::R_OP2_W];
    assign e_field = instruction[ctrl_pkg::E_OP2_LSB +: ctrl_pkg::E_OP2_W];
    assign r_field = instruction[ctrl_pkg::R_REG2_LSB +: ctrl_pkg::R_REG2_W];
    assign e_imm   = instruction[ctrl_pkg::E_IMM_LSB +: ctrl_pkg::E_IMM_W];
    assign t_imm   = instruction[ctrl_pkg::T_IMM_LSB +: ctrl_pkg::T_IMM_W];

    // Every field ends at bit 15, so its top bit is the sign.
    assign e_imm_sx = {{(ctrl_pkg::WORD_W - ctrl_pkg::E_IMM_W){e_imm[ctrl_pkg::E_IMM_W-1]}}, e_imm};
    assign e_imm_zx = {{(ctrl_pkg::WORD_W - ctrl_pkg::E_IMM_W){1'b0}}, e_imm};
    assign t_imm_sx = {{(ctrl_pkg::WORD_W - ctrl_pkg::T_IMM_W){t_imm[ctrl_pkg::T_IMM_W-1]}}, t_imm};
    assign t_imm_zx = {{(ctrl_pkg::WORD_W - ctrl_pkg::T_IMM_W){1'b0}}, t_imm};
    assign r_imm_zx = {{(ctrl_pkg::WORD_W - ctrl_pkg::R_REG2_W){1'b0}}, r_field};

    always_comb begin
        case (opcode1)
            ctrl_pkg::LDR:      op = ctrl_pkg::OP_LDR;
            ctrl_pkg::LDRU:     op = ctrl_pkg::OP_LDRU;
            ctrl_pkg::LD_MPTR:  op = ctrl_pkg::OP_LD_MPTR;
            ctrl_pkg::ST_MPTR:  op = ctrl_pkg::OP_ST_MPTR;
            ctrl_pkg::LDB_MPTR: op = ctrl_pkg::OP_LDB_MPTR;
            ctrl_pkg::STB_MPTR: op = ctrl_pkg::OP_STB_MPTR;
            ctrl_pkg::LDA:      op = ctrl_pkg::OP_LDA;
            ctrl_pkg::LDMPTR:   op = ctrl_pkg::OP_LDMPTR;
            ctrl_pkg::LDMPTRU:  op = ctrl_pkg::OP_LDMPTRU;
            ctrl_pkg::SJMP:     op = ctrl_pkg::OP_SJMP;
            ctrl_pkg::SJMPF:    op = ctrl_pkg::OP_SJMPF;
            ctrl_pkg::GRP_E:    op = ctrl_pkg::OP_ALU_IMM;
            ctrl_pkg::GRP_R: begin
                case (r_op2)
                    ctrl_pkg::OP2_LDAU: op = ctrl_pkg::OP_LDAU;
                    ctrl_pkg::OP2_POP:  op = ctrl_pkg::OP_POP;
                    ctrl_pkg::OP2_PUSH: op = ctrl_pkg::OP_PUSH;
                    ctrl_pkg::OP2_INC:  op = ctrl_pkg::OP_INC;
                    ctrl_pkg::OP2_DEC:  op = ctrl_pkg::OP_DEC;
                    default: begin
                        op = (r_op2 >= ctrl_pkg::OP2_SHIFT_MIN) ? ctrl_pkg::OP_SHIFT_IMM
                                                                : ctrl_pkg::OP_ALU_REG;
                    end
                endcase
            end
            default:            op = ctrl_pkg::OP_NOP;  // MOV and the unused 1110 and 1111.
        endcase
    end

    always_comb begin
        case (op)
            ctrl_pkg::OP_LDR, ctrl_pkg::OP_ALU_IMM:                   data_word = e_imm_sx;
            ctrl_pkg::OP_LDRU:                                        data_word = e_imm_zx;
            ctrl_pkg::OP_LDA, ctrl_pkg::OP_SJMP, ctrl_pkg::OP_SJMPF:  data_word = t_imm_sx;
            ctrl_pkg::OP_LDMPTR, ctrl_pkg::OP_LDMPTRU:                data_word = t_imm_zx;
            ctrl_pkg::OP_LDAU, ctrl_pkg::OP_SHIFT_IMM:                data_word = r_imm_zx;
            default:                                                  data_word = '0;
        endcase
    end

    assign reg_id = (opcode1 == ctrl_pkg::GRP_R) ? r_field
                  : {{(ctrl_pkg::REG_ID_W - ctrl_pkg::E_OP2_W){1'b0}}, e_field};
    assign alu_opcode = (opcode1 == ctrl_pkg::GRP_E) ? {1'b0, e_field}
                      : r_op2[ctrl_pkg::ALU_OP_W-1:0];
    assign mptr_offsetin = {{(ctrl_pkg::MPTR_OFS_W - ctrl_pkg::E_IMM_W){1'b0}}, e_imm};

endmodule

// File: verilog/ctrl_pkg.sv
// Shared widths, instruction field positions and state encodings for the control decoder.
package ctrl_pkg;

    localparam int WORD_W     = 16;
    localparam int REG_ID_W   = 6;
    localparam int ALU_OP_W   = 5;
    localparam int MPTR_OFS_W = 12;

    localparam int OPC1_LSB   = 0;
    localparam int OPC1_W     = 4;
    localparam int R_OP2_LSB  = 4;  // R-type opcode2, also R-type reg1.
    localparam int R_OP2_W    = 6;
    localparam int E_OP2_LSB  = 4;  // E-type opcode2, also E-type reg1.
    localparam int E_OP2_W    = 4;
    localparam int R_REG2_LSB = 10; // R-type reg2, also R-type immediate.
    localparam int R_REG2_W   = 6;
    localparam int E_IMM_LSB  = 8;  // E-type immediate, also E-type offset.
    localparam int E_IMM_W    = 8;
    localparam int T_IMM_LSB  = 4;  // T-type immediate, also T-type offset.
    localparam int T_IMM_W    = 12;

    // Opcode2 codes of the 1100 group.
    localparam logic [R_OP2_W-1:0] OP2_LDAU      = 6'd59;
    localparam logic [R_OP2_W-1:0] OP2_POP       = 6'd60;
    localparam logic [R_OP2_W-1:0] OP2_PUSH      = 6'd61;
    localparam logic [R_OP2_W-1:0] OP2_INC       = 6'd62;
    localparam logic [R_OP2_W-1:0] OP2_DEC       = 6'd63;
    localparam logic [R_OP2_W-1:0] OP2_SHIFT_MIN = 6'd32; // Shifts run up to 58.

    typedef enum logic [OPC1_W-1:0] {
        LDR      = 4'b0000,
        LDRU     = 4'b0001,
        LD_MPTR  = 4'b0010,
        ST_MPTR  = 4'b0011,
        LDB_MPTR = 4'b0100,
        STB_MPTR = 4'b0101,
        LDA      = 4'b0110,
        LDMPTR   = 4'b0111,
        LDMPTRU  = 4'b1000,
        MOV      = 4'b1001,
        SJMP     = 4'b1010,
        SJMPF    = 4'b1011,
        GRP_R    = 4'b1100,
        GRP_E    = 4'b1101
    } opcode1_t;

    typedef enum logic [4:0] {
        OP_LDR, OP_LDRU, OP_LD_MPTR, OP_ST_MPTR, OP_LDB_MPTR, OP_STB_MPTR,
        OP_LDA, OP_LDAU, OP_LDMPTR, OP_LDMPTRU, OP_SJMP, OP_SJMPF,
        OP_PUSH, OP_POP, OP_INC, OP_DEC,
        OP_SHIFT_IMM, OP_ALU_REG, OP_ALU_IMM, OP_NOP
    } op_t;

    typedef enum logic [2:0] {
        FETCH_LO, FETCH_HI, EXEC_0, EXEC_1, EXEC_2, EXEC_3
    } phase_t;

endpackage
